//--- verilog/audio_filter_macros.svh
// Audio filter constants
// Word widths, tap counts, Wishbone register map and the power-up
// coefficient set of the fourth-order band-pass (2.16, scaled by 1/4)

`ifndef AUDIO_FILTER_MACROS_SVH
`define AUDIO_FILTER_MACROS_SVH

// ---------------------------------------------------------------------------
// Widths and taps
`define AF_SAMPLE_W   16     // Codec sample
`define AF_DATA_W     18     // Internal 2.16 word
`define AF_FRAC_W     16
`define AF_OUT_SHIFT  2      // Undo the 1/4 coefficient scaling
`define AF_NUM_B      5      // b1..b5
`define AF_NUM_A      4      // a2..a5, a1 implied
`define AF_ADDR_W     4      // Word address

// ---------------------------------------------------------------------------
// Register map
`define AF_REG_B1     4'd0
`define AF_REG_B2     4'd1
`define AF_REG_B3     4'd2
`define AF_REG_B4     4'd3
`define AF_REG_B5     4'd4
`define AF_REG_A2     4'd5
`define AF_REG_A3     4'd6
`define AF_REG_A4     4'd7
`define AF_REG_A5     4'd8
`define AF_REG_CTRL   4'd9   // Bit 0 enables the filter

// Butterworth band-pass 0.1..0.2, feedback signs inverted
`define AF_RST_B1     18'h00149
`define AF_RST_B2     18'h00000
`define AF_RST_B3     18'h3FD6E
`define AF_RST_B4     18'h00000
`define AF_RST_B5     18'h00149
`define AF_RST_A2     18'h0CD98
`define AF_RST_A3     18'h2F54E
`define AF_RST_A4     18'h0A42E
`define AF_RST_A5     18'h3D6F5

`endif

//--- verilog/audio_filter_pkg.sv
// Audio filter shared types
// Sequencer states and the bundles passed between the register
// block, the tap sequencer and the MAC

`default_nettype none

`include "audio_filter_macros.svh"

package audio_filter_pkg;

	// Per-frame sequence, one step per fast clock
	typedef enum logic [2:0] {
		IDLE,                 // Waiting for LR clock edge
		LOAD,                 // b1 * x(n), acc cleared
		FEED,                 // b2..b5 against x history
		BACK,                 // a2..a5 against y history
		UPDATE                // Shift histories, publish
	} seq_state_t;

	// Full coefficient set, 2.16
	typedef struct packed {
		logic signed [`AF_DATA_W-1:0] b1;
		logic signed [`AF_DATA_W-1:0] b2;
		logic signed [`AF_DATA_W-1:0] b3;
		logic signed [`AF_DATA_W-1:0] b4;
		logic signed [`AF_DATA_W-1:0] b5;
		logic signed [`AF_DATA_W-1:0] a2;
		logic signed [`AF_DATA_W-1:0] a3;
		logic signed [`AF_DATA_W-1:0] a4;
		logic signed [`AF_DATA_W-1:0] a5;
	} coeff_set_t;

	// Wishbone classic, host to slave
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [`AF_ADDR_W-1:0] adr;
		logic [31:0]           dat_w;
	} wb_req_t;

	// Wishbone classic, slave to host
	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

	// One multiply-accumulate step
	typedef struct packed {
		logic                         clear;   // Start acc from zero
		logic                         valid;
		logic signed [`AF_DATA_W-1:0] coeff;
		logic signed [`AF_DATA_W-1:0] value;
	} mac_op_t;

endpackage

`default_nettype wire

//--- verilog/coeff_regs.sv
// Coefficient register block
// Wishbone classic slave holding the nine filter coefficients and
// the enable bit, single-cycle ack, sign-extended read-back

`timescale 1ns/1ns
`default_nettype none

`include "audio_filter_macros.svh"

module coeff_regs
(
	input	wire logic							AUD_CTRL_CLK,
	input	wire logic							reset,
	input	wire audio_filter_pkg::wb_req_t		wb_req,
	output	audio_filter_pkg::wb_rsp_t			wb_rsp,
	output	audio_filter_pkg::coeff_set_t		coeffs,
	output	logic								enable
);

	logic							access;		// Strobe seen, no ack pending
	logic							ack_q;
	logic	[31:0]					rd_data;	// Muxed by address
	logic	[31:0]					rd_q;
	logic	[`AF_DATA_W-1:0]		wr_coeff;
	audio_filter_pkg::coeff_set_t	coeffs_q;
	logic							enable_q;

	// Coefficient to 32-bit bus word
	function automatic logic [31:0] sext(input logic [`AF_DATA_W-1:0] v);
		return {{(32-`AF_DATA_W){v[`AF_DATA_W-1]}}, v};
	endfunction

	assign access	= wb_req.cyc & wb_req.stb & ~ack_q;
	assign wr_coeff	= wb_req.dat_w[`AF_DATA_W-1:0];		// Low bits only

	// ------------------------------------------------------------------------
	// Bus handshake
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= access;			// High one cycle, drops while cyc held
	end

	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (access)
			rd_q <= rd_data;			// Held until next access
	end

	assign wb_rsp = '{ack: ack_q, dat_r: rd_q};

	// ------------------------------------------------------------------------
	// Register file
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
		begin
			coeffs_q.b1	<= `AF_RST_B1;
			coeffs_q.b2	<= `AF_RST_B2;
			coeffs_q.b3	<= `AF_RST_B3;
			coeffs_q.b4	<= `AF_RST_B4;
			coeffs_q.b5	<= `AF_RST_B5;
			coeffs_q.a2	<= `AF_RST_A2;
			coeffs_q.a3	<= `AF_RST_A3;
			coeffs_q.a4	<= `AF_RST_A4;
			coeffs_q.a5	<= `AF_RST_A5;
			enable_q	<= 1'b1;		// Filter runs out of reset
		end
		else if (access && wb_req.we)
		begin
			case (wb_req.adr)
				`AF_REG_B1:		coeffs_q.b1 <= wr_coeff;
				`AF_REG_B2:		coeffs_q.b2 <= wr_coeff;
				`AF_REG_B3:		coeffs_q.b3 <= wr_coeff;
				`AF_REG_B4:		coeffs_q.b4 <= wr_coeff;
				`AF_REG_B5:		coeffs_q.b5 <= wr_coeff;
				`AF_REG_A2:		coeffs_q.a2 <= wr_coeff;
				`AF_REG_A3:		coeffs_q.a3 <= wr_coeff;
				`AF_REG_A4:		coeffs_q.a4 <= wr_coeff;
				`AF_REG_A5:		coeffs_q.a5 <= wr_coeff;
				`AF_REG_CTRL:	enable_q <= wb_req.dat_w[0];
				default:		;						// Unmapped, dropped
			endcase
		end
	end

	// Read mux
	always_comb
	begin
		case (wb_req.adr)
			`AF_REG_B1:		rd_data = sext(coeffs_q.b1);
			`AF_REG_B2:		rd_data = sext(coeffs_q.b2);
			`AF_REG_B3:		rd_data = sext(coeffs_q.b3);
			`AF_REG_B4:		rd_data = sext(coeffs_q.b4);
			`AF_REG_B5:		rd_data = sext(coeffs_q.b5);
			`AF_REG_A2:		rd_data = sext(coeffs_q.a2);
			`AF_REG_A3:		rd_data = sext(coeffs_q.a3);
			`AF_REG_A4:		rd_data = sext(coeffs_q.a4);
			`AF_REG_A5:		rd_data = sext(coeffs_q.a5);
			`AF_REG_CTRL:	rd_data = {31'd0, enable_q};
			default:		rd_data = 32'd0;
		endcase
	end

	assign coeffs = coeffs_q;
	assign enable = enable_q;

endmodule

`default_nettype wire

//--- verilog/mac_unit.sv
// Shared multiply-accumulate
// 2.16 signed product, truncated to 18 bits, summed into a wrapping
// accumulator; output is the accumulator times four

`timescale 1ns/1ns
`default_nettype none

`include "audio_filter_macros.svh"

module mac_unit
(
	input	wire logic							AUD_CTRL_CLK,
	input	wire logic							reset,
	input	wire audio_filter_pkg::mac_op_t		mac_op,
	output	logic signed [`AF_DATA_W-1:0]		acc_scaled
);

	localparam int PROD_W	= 2 * `AF_DATA_W;
	localparam int PROD_TOP	= `AF_FRAC_W + `AF_DATA_W - 2;	// Highest kept magnitude bit

	logic signed	[PROD_W-1:0]		product;
	logic signed	[`AF_DATA_W-1:0]	prod_trunc;
	logic signed	[`AF_DATA_W-1:0]	acc_base;
	logic signed	[`AF_DATA_W-1:0]	acc;

	// ------------------------------------------------------------------------
	// Product
	assign product = $signed(mac_op.coeff) * $signed(mac_op.value);

	// Sign, then integer bit and fraction; fraction tail dropped
	assign prod_trunc = {product[PROD_W-1], product[PROD_TOP -: `AF_DATA_W-1]};

	// ------------------------------------------------------------------------
	// Accumulator
	assign acc_base = mac_op.clear ? '0 : acc;		// First tap of a frame

	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
			acc <= '0;
		else if (mac_op.valid)
			acc <= acc_base + prod_trunc;			// 18-bit wrap, no saturation
	end

	// Coefficients were scaled by 1/4
	assign acc_scaled = acc <<< `AF_OUT_SHIFT;

endmodule

`default_nettype wire

//--- verilog/iir_sequencer.sv
// IIR tap sequencer
// Catches the LR clock rising edge, then walks b1..b5 and a2..a5
// through the shared MAC, keeps the x and y histories and publishes
// the filtered and dry samples once per frame

`timescale 1ns/1ns
`default_nettype none

`include "audio_filter_macros.svh"

module iir_sequencer
(
	input	wire logic							AUD_CTRL_CLK,
	input	wire logic							reset,
	input	wire logic							lrck,
	input	wire logic signed [`AF_SAMPLE_W-1:0]	audio_in,
	input	wire audio_filter_pkg::coeff_set_t	coeffs,
	input	wire logic							enable,
	output	audio_filter_pkg::mac_op_t			mac_op,
	input	wire logic signed [`AF_DATA_W-1:0]	acc_scaled,
	output	logic signed [`AF_SAMPLE_W-1:0]		filt_out,
	output	logic signed [`AF_SAMPLE_W-1:0]		dry_out,
	output	logic								out_valid
);

	localparam int PAD_W	= `AF_DATA_W - `AF_SAMPLE_W;	// Sample to 2.16
	localparam int TAP_W	= $clog2(`AF_NUM_A);

	audio_filter_pkg::seq_state_t	state;
	logic	[TAP_W-1:0]				tap;			// Step within FEED or BACK
	logic							lrck_meta;
	logic							lrck_sync;
	logic							lrck_prev;		// Edge register
	logic							lrck_rise;
	logic signed	[`AF_DATA_W-1:0]	x_in;
	logic signed	[`AF_DATA_W-1:0]	x_n;			// Frame input, 2.16
	logic signed	[`AF_DATA_W-1:0]	x_hist [1:`AF_NUM_B-1];	// x(n-1)..x(n-4)
	logic signed	[`AF_DATA_W-1:0]	y_hist [1:`AF_NUM_A];	// y(n-1)..y(n-4)

	assign x_in = {audio_in, {PAD_W{1'b0}}};

	// ------------------------------------------------------------------------
	// Frame start, seen three cycles after lrck rises
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
		begin
			lrck_meta	<= 1'b0;
			lrck_sync	<= 1'b0;
			lrck_prev	<= 1'b0;
			lrck_rise	<= 1'b0;
		end
		else
		begin
			lrck_meta	<= lrck;
			lrck_sync	<= lrck_meta;
			lrck_prev	<= lrck_sync;
			lrck_rise	<= lrck_sync & ~lrck_prev;
		end
	end

	// ------------------------------------------------------------------------
	// Tap-stepping FSM
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
		begin
			state	<= audio_filter_pkg::IDLE;
			tap		<= '0;
		end
		else
		begin
			case (state)
				audio_filter_pkg::IDLE:
				begin
					if (lrck_rise && enable)		// Edges elsewhere are dropped
						state <= audio_filter_pkg::LOAD;
				end
				audio_filter_pkg::LOAD:
				begin
					tap		<= '0;
					state	<= audio_filter_pkg::FEED;
				end
				audio_filter_pkg::FEED:
				begin
					if (tap == TAP_W'(`AF_NUM_B - 2))
					begin
						tap		<= '0;
						state	<= audio_filter_pkg::BACK;
					end
					else
						tap <= tap + 1'b1;
				end
				audio_filter_pkg::BACK:
				begin
					if (tap == TAP_W'(`AF_NUM_A - 1))
						state <= audio_filter_pkg::UPDATE;
					else
						tap <= tap + 1'b1;
				end
				default:
					state <= audio_filter_pkg::IDLE;		// UPDATE and strays
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// MAC step selection
	always_comb
	begin
		mac_op.clear	= (state == audio_filter_pkg::LOAD);
		mac_op.valid	= (state == audio_filter_pkg::LOAD) ||
						  (state == audio_filter_pkg::FEED) ||
						  (state == audio_filter_pkg::BACK);
		mac_op.coeff	= '0;
		mac_op.value	= '0;
		case (state)
			audio_filter_pkg::LOAD:
			begin
				mac_op.coeff = coeffs.b1;
				mac_op.value = x_in;					// Live sample, x(n)
			end
			audio_filter_pkg::FEED:
			begin
				mac_op.value = x_hist[int'(tap) + 1];
				case (tap)
					2'd0:		mac_op.coeff = coeffs.b2;
					2'd1:		mac_op.coeff = coeffs.b3;
					2'd2:		mac_op.coeff = coeffs.b4;
					default:	mac_op.coeff = coeffs.b5;
				endcase
			end
			audio_filter_pkg::BACK:
			begin
				mac_op.value = y_hist[int'(tap) + 1];	// Signs already inverted
				case (tap)
					2'd0:		mac_op.coeff = coeffs.a2;
					2'd1:		mac_op.coeff = coeffs.a3;
					2'd2:		mac_op.coeff = coeffs.a4;
					default:	mac_op.coeff = coeffs.a5;
				endcase
			end
			default:	;
		endcase
	end

	// ------------------------------------------------------------------------
	// Histories and outputs
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (state == audio_filter_pkg::LOAD)
			x_n <= x_in;								// Also the dry sample
	end

	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (reset)
		begin
			for (int i = 1; i <= `AF_NUM_B - 1; i++)
				x_hist[i] <= '0;
			for (int i = 1; i <= `AF_NUM_A; i++)
				y_hist[i] <= '0;
			filt_out	<= '0;
			dry_out		<= '0;
			out_valid	<= 1'b0;
		end
		else
		begin
			out_valid <= (state == audio_filter_pkg::UPDATE);	// Cycle after UPDATE
			if (state == audio_filter_pkg::UPDATE)
			begin
				x_hist[1] <= x_n;
				for (int i = 2; i <= `AF_NUM_B - 1; i++)
					x_hist[i] <= x_hist[i-1];
				y_hist[1] <= acc_scaled;				// y(n) becomes y(n-1)
				for (int i = 2; i <= `AF_NUM_A; i++)
					y_hist[i] <= y_hist[i-1];
				filt_out	<= acc_scaled[`AF_DATA_W-1 -: `AF_SAMPLE_W];
				dry_out		<= x_n[`AF_DATA_W-1 -: `AF_SAMPLE_W];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/audio_filter_top.sv
// Audio filter top level
// Wishbone coefficient registers, tap sequencer and the shared MAC
// for the fourth-order band-pass on the right channel

`timescale 1ns/1ns
`default_nettype none

`include "audio_filter_macros.svh"

module audio_filter_top
(
	input	wire logic							AUD_CTRL_CLK,
	input	wire logic							reset,
	input	wire audio_filter_pkg::wb_req_t		wb_req,
	output	audio_filter_pkg::wb_rsp_t			wb_rsp,
	input	wire logic							lrck,		// DAC LR clock
	input	wire logic signed [`AF_SAMPLE_W-1:0]	audio_in,
	output	logic signed [`AF_SAMPLE_W-1:0]		filt_out,
	output	logic signed [`AF_SAMPLE_W-1:0]		dry_out,
	output	logic								out_valid
);

	audio_filter_pkg::coeff_set_t		coeffs;
	logic								enable;
	audio_filter_pkg::mac_op_t			mac_op;		// One step per cycle
	logic signed	[`AF_DATA_W-1:0]	acc_scaled;

	// ------------------------------------------------------------------------
	coeff_regs i_coeff_regs (
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.wb_req			(wb_req),
		.wb_rsp			(wb_rsp),
		.coeffs			(coeffs),
		.enable			(enable)
	);

	iir_sequencer i_iir_sequencer (
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.lrck			(lrck),
		.audio_in		(audio_in),
		.coeffs			(coeffs),
		.enable			(enable),
		.mac_op			(mac_op),
		.acc_scaled		(acc_scaled),
		.filt_out		(filt_out),
		.dry_out		(dry_out),
		.out_valid		(out_valid)
	);

	mac_unit i_mac_unit (
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.mac_op			(mac_op),
		.acc_scaled		(acc_scaled)
	);

endmodule

`default_nettype wire

//--- sim/audio_filter_assert.sv
// Audio filter protocol checks
// Bound to the top level, covers the Wishbone ack pulse and the
// timing of the filtered and dry outputs

`timescale 1ns/1ns
`default_nettype none

`include "audio_filter_macros.svh"

module audio_filter_assert
(
	input	wire logic								AUD_CTRL_CLK,
	input	wire logic								reset,
	input	wire audio_filter_pkg::wb_rsp_t			wb_rsp,
	input	wire logic								out_valid,
	input	wire logic signed [`AF_SAMPLE_W-1:0]	filt_out,
	input	wire logic signed [`AF_SAMPLE_W-1:0]	dry_out
);

	// ------------------------------------------------------------------------
	// Bus side
	ack_single: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("Wishbone ack held high for two cycles");

	// ------------------------------------------------------------------------
	// Sample side
	valid_pulse: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		out_valid |=> !out_valid)		// One cycle per frame
		else $error("out_valid high for more than one cycle");

	// Outputs move only together with the out_valid pulse
	out_stable: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		!$rose(out_valid) |-> ($stable(filt_out) && $stable(dry_out)))
		else $error("filt_out or dry_out changed outside an out_valid pulse");

endmodule

bind audio_filter_top audio_filter_assert i_audio_filter_assert (
	.AUD_CTRL_CLK	(AUD_CTRL_CLK),
	.reset			(reset),
	.wb_rsp			(wb_rsp),
	.out_valid		(out_valid),
	.filt_out		(filt_out),
	.dry_out		(dry_out)
);

`default_nettype wire

//--- sim/audio_filter_tb.sv
// Audio filter testbench
// Register read-back over Wishbone, then a table of filter settings
// and sample streams checked against tabled values or a bit-true model

`timescale 1ns/1ns
`default_nettype none

`include "audio_filter_macros.svh"

module audio_filter_tb;

	typedef enum logic [1:0] {SRC_TABLE, SRC_CONST, SRC_STEP, SRC_RAND} src_t;

	typedef struct packed {
		audio_filter_pkg::coeff_set_t	cs;
		logic							en;		// Control register bit 0
		logic	[7:0]					n;		// Frames in this row
		src_t							src;
		logic							model;	// Model output or tabled value
	} row_t;

	localparam int NUM_ROWS		= 6;
	localparam int NUM_COEFFS	= `AF_NUM_B + `AF_NUM_A;
	localparam int FRAME_HALF	= 24;		// lrck toggles every 24 cycles
	localparam int LATENCY		= 14;		// lrck rise to out_valid
	localparam int WB_WAIT		= 16;

	// ------------------------------------------------------------------------
	// Coefficient sets in register order b1..b5 then a2..a5
	localparam audio_filter_pkg::coeff_set_t RESET_CS = {`AF_RST_B1, `AF_RST_B2,
		`AF_RST_B3, `AF_RST_B4, `AF_RST_B5, `AF_RST_A2, `AF_RST_A3, `AF_RST_A4, `AF_RST_A5};
	localparam audio_filter_pkg::coeff_set_t IDENT_CS	= {18'h04000, {8{18'h0}}};
	localparam audio_filter_pkg::coeff_set_t DELAY_CS	= {36'h0, 18'h04000, {6{18'h0}}};
	localparam audio_filter_pkg::coeff_set_t FEEDBK_CS	=
		{18'h04000, {4{18'h0}}, 18'h02000, {3{18'h0}}};	// y(n) = x(n) + y(n-1)/2

	localparam row_t ROWS [NUM_ROWS] = '{
		'{cs: RESET_CS,  en: 1'b1, n: 8'd12, src: SRC_RAND,  model: 1'b1},
		'{cs: IDENT_CS,  en: 1'b1, n: 8'd6,  src: SRC_TABLE, model: 1'b0},
		'{cs: DELAY_CS,  en: 1'b1, n: 8'd6,  src: SRC_TABLE, model: 1'b0},
		'{cs: FEEDBK_CS, en: 1'b1, n: 8'd7,  src: SRC_TABLE, model: 1'b0},
		'{cs: RESET_CS,  en: 1'b0, n: 8'd3,  src: SRC_CONST, model: 1'b0},	// Disabled
		'{cs: RESET_CS,  en: 1'b1, n: 8'd8,  src: SRC_STEP,  model: 1'b1}
	};

	localparam logic [15:0] SMP_TAB [NUM_ROWS][8] = '{
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h0100, 16'h7FFF, 16'h8000, 16'h1234, 16'hFEDC, 16'h0001, 16'h0000, 16'h0000},
		'{16'h2222, 16'hC001, 16'h0777, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h4000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h1111, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h3000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};

	localparam logic [15:0] EXP_TAB [NUM_ROWS][8] = '{
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h0100, 16'h7FFF, 16'h8000, 16'h1234, 16'hFEDC, 16'h0001, 16'h0000, 16'h0000},
		'{16'hFEDC, 16'h0001, 16'h2222, 16'hC001, 16'h0777, 16'h0000, 16'h0000, 16'h0000},
		'{16'h4000, 16'h2000, 16'h1000, 16'h0800, 16'h0400, 16'h0200, 16'h0100, 16'h0000},
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};

	logic							AUD_CTRL_CLK;
	logic							reset;
	audio_filter_pkg::wb_req_t		wb_req;
	audio_filter_pkg::wb_rsp_t		wb_rsp;
	logic							lrck;
	logic signed	[15:0]			audio_in;
	logic signed	[15:0]			filt_out;
	logic signed	[15:0]			dry_out;
	logic							out_valid;

	int								errors;
	int								cycles;
	int								limit;			// Timeout in cycles
	audio_filter_pkg::coeff_set_t	cur_cs;			// Set the model runs with
	logic signed	[17:0]			mx [1:4];		// Model x(n-1)..x(n-4)
	logic signed	[17:0]			my [1:4];		// Model y(n-1)..y(n-4)

	audio_filter_top i_audio_filter_top (
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.wb_req			(wb_req),
		.wb_rsp			(wb_rsp),
		.lrck			(lrck),
		.audio_in		(audio_in),
		.filt_out		(filt_out),
		.dry_out		(dry_out),
		.out_valid		(out_valid)
	);

	initial
	begin
		AUD_CTRL_CLK = 1'b0;
		forever #4 AUD_CTRL_CLK = ~AUD_CTRL_CLK;	// 8 ns period
	end

	always @(posedge AUD_CTRL_CLK)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout, run exceeded %0d cycles", limit);
			$display("Checks done, %0d errors", errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Reporting and reference arithmetic
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	function automatic logic [31:0] sext(input logic [17:0] v);
		return {{14{v[17]}}, v};
	endfunction

	// Register address a holds field a of the set with b1 first
	function automatic logic [17:0] coeff_at(input audio_filter_pkg::coeff_set_t cs,
		input int a);
		return cs[(NUM_COEFFS - 1 - a) * 18 +: 18];
	endfunction

	// Fraction bits shifted out and the sign kept on top
	function automatic logic signed [17:0] trunc_product(input logic signed [17:0] c,
		input logic signed [17:0] v);
		logic signed [35:0] p;
		logic signed [35:0] q;
		p = 36'(c) * 36'(v);
		q = p >>> 16;
		return {p[35], q[16:0]};
	endfunction

	function logic [15:0] filter_model(input logic [15:0] s);
		logic signed [17:0] x0;
		logic signed [17:0] acc;
		logic signed [17:0] y;
		x0 = {s, 2'b00};
		acc = trunc_product(cur_cs.b1, x0);
		acc = acc + trunc_product(cur_cs.b2, mx[1]);
		acc = acc + trunc_product(cur_cs.b3, mx[2]);
		acc = acc + trunc_product(cur_cs.b4, mx[3]);
		acc = acc + trunc_product(cur_cs.b5, mx[4]);
		acc = acc + trunc_product(cur_cs.a2, my[1]);	// Feedback signs pre-inverted
		acc = acc + trunc_product(cur_cs.a3, my[2]);
		acc = acc + trunc_product(cur_cs.a4, my[3]);
		acc = acc + trunc_product(cur_cs.a5, my[4]);
		y = acc <<< 2;									// Undo quarter scaling
		for (int i = 4; i >= 2; i--)
		begin
			mx[i] = mx[i-1];
			my[i] = my[i-1];
		end
		mx[1] = x0;
		my[1] = y;
		return y[17:2];
	endfunction

	// ------------------------------------------------------------------------
	// Bus and frame tasks start and end 1 ns after a rising edge
	task automatic wb_access(input logic we, input logic [3:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
		waited = 0;
		do
		begin
			@(posedge AUD_CTRL_CLK);
			#1;
			waited++;
		end
		while (!wb_rsp.ack && waited < WB_WAIT);
		assert (wb_rsp.ack)
			else report_problem($sformatf("No Wishbone ack at address %0d", adr));
		rdata = wb_rsp.dat_r;
		wb_req = '0;
	endtask

	task automatic check_reg(input logic [3:0] adr, input logic [31:0] exp);
		logic [31:0] rd;
		wb_access(1'b0, adr, 32'd0, rd);
		assert (rd === exp) else report_mismatch($sformatf("dat_r @%0d", adr), rd, exp);
	endtask

	// One lrck period that records the first out_valid and its cycle
	task automatic run_frame(input logic [15:0] s, output logic seen, output int lat,
		output logic [15:0] f, output logic [15:0] d);
		seen = 1'b0;
		lat = 0;
		f = '0;
		d = '0;
		audio_in = s;
		lrck = 1'b1;
		for (int c = 1; c <= 2 * FRAME_HALF; c++)
		begin
			@(posedge AUD_CTRL_CLK);
			#1;
			if (c == FRAME_HALF)
				lrck = 1'b0;
			if (out_valid && !seen)
			begin
				seen = 1'b1;
				lat = c;
				f = filt_out;
				d = dry_out;
			end
		end
	endtask

	task automatic apply_row(input int r);
		row_t			row;
		logic	[31:0]	rd;
		logic	[31:0]	rnd;
		logic	[15:0]	s;
		logic	[15:0]	f;
		logic	[15:0]	d;
		logic	[15:0]	exp_f;
		logic			seen;
		int				lat;
		row = ROWS[r];
		for (int a = 0; a < NUM_COEFFS; a++)
			wb_access(1'b1, 4'(a), sext(coeff_at(row.cs, a)), rd);	// Between frames
		wb_access(1'b1, `AF_REG_CTRL, {31'd0, row.en}, rd);
		cur_cs = row.cs;
		for (int k = 0; k < int'(row.n); k++)
		begin
			case (row.src)
				SRC_TABLE:	s = SMP_TAB[r][k];
				SRC_CONST:	s = SMP_TAB[r][0];
				SRC_STEP:	s = (k == 0) ? 16'h0000 : SMP_TAB[r][0];
				default:
				begin
					rnd = $urandom();
					s = rnd[15:0];
				end
			endcase
			run_frame(s, seen, lat, f, d);
			if (row.en)
			begin
				exp_f = filter_model(s);			// Model histories follow every frame
				if (!row.model)
					exp_f = EXP_TAB[r][k];
				assert (seen)
					else report_problem($sformatf("No out_valid in row %0d frame %0d", r, k));
				assert (lat == LATENCY)
					else report_mismatch("out_valid latency", 32'(lat), 32'(LATENCY));
				assert (f === exp_f)
					else report_mismatch($sformatf("filt_out row %0d frame %0d", r, k),
						32'(f), 32'(exp_f));
				assert (d === s)
					else report_mismatch($sformatf("dry_out row %0d frame %0d", r, k),
						32'(d), 32'(s));
			end
			else
				assert (!seen)
					else report_problem($sformatf("out_valid while disabled, row %0d", r));
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	initial
	begin
		int				total;
		logic	[31:0]	rd;
		errors = 0;
		cycles = 0;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total += int'(ROWS[r].n);
		limit = (total + 10) * 2 * FRAME_HALF + 200;
		void'($urandom(32'h7b48_4278));
		reset = 1'b1;
		lrck = 1'b0;
		audio_in = '0;
		wb_req = '0;
		for (int i = 1; i <= 4; i++)
		begin
			mx[i] = '0;
			my[i] = '0;
		end
		repeat (4) @(posedge AUD_CTRL_CLK);
		#1;
		reset = 1'b0;

		// Unmapped access must leave the reset values untouched
		check_reg(4'd12, 32'd0);
		wb_access(1'b1, 4'd12, 32'hFFFF_FFFF, rd);		// Dropped by the slave
		for (int a = 0; a < NUM_COEFFS; a++)
			check_reg(4'(a), sext(coeff_at(RESET_CS, a)));
		check_reg(`AF_REG_CTRL, 32'd1);
		wb_access(1'b1, `AF_REG_A3, 32'h0002_1357, rd);
		check_reg(`AF_REG_A3, sext(18'h21357));

		for (int r = 0; r < NUM_ROWS; r++)
			apply_row(r);

		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/audio_filter_pkg.sv
verilog/coeff_regs.sv
verilog/mac_unit.sv
verilog/iir_sequencer.sv
verilog/audio_filter_top.sv
sim/audio_filter_assert.sv
sim/audio_filter_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the audio filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module audio_filter_tb \
	-Mdir obj_dir \
	-f all.f

status=0
output=$(./obj_dir/Vaudio_filter_tb) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
	exit 0
fi
echo "Simulation failed, exit status $status"
exit 1
